//--- hdl/edge_pkg.sv
package edge_pkg;

	// interior image size, the host adds a one-pixel zero border around it
	localparam int IMG_WIDTH = 8;
	localparam int IMG_HEIGHT = 6;

	// padded row length
	// one zero pixel at each end of every row
	localparam int ROW_DEPTH = IMG_WIDTH + 2;

	// padded frame height, one zero row above and one below
	localparam int FRAME_ROWS = IMG_HEIGHT + 2;

	// counter widths for the line window
	localparam int COL_W = $clog2(ROW_DEPTH);
	localparam int ROW_W = $clog2(FRAME_ROWS);

	// rgb pixel, red in the top byte
	localparam int PIX_W = 24;
	localparam int CH_W = 8;

	// signed gradient per channel
	// worst case is 4 * 255 = 1020, so 12 bits with sign
	localparam int GRAD_W = 12;

	// horizontal sobel kernel, row-major, top row first
	localparam int KERNEL_X [3][3] = '{
		'{-1, 0, 1},
		'{-2, 0, 2},
		'{-1, 0, 1}
	};

	// vertical kernel is the transpose of the horizontal one
	localparam int KERNEL_Y [3][3] = '{
		'{-1, -2, -1},
		'{ 0,  0,  0},
		'{ 1,  2,  1}
	};

	// accepted beats from the beat that completes a window to its result
	// 1 in line_window, 2 in sobel_conv, 1 in edge_combine
	localparam int PIPE_BEATS = 4;

endpackage

//--- hdl/line_window.sv
module line_window (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_valid,
	input  logic [edge_pkg::PIX_W-1:0]    i_data,
	output logic [9*edge_pkg::PIX_W-1:0]  o_win,
	output logic                          o_win_valid,
	output logic                          o_win_done
);
	import edge_pkg::*;

	// two row buffers, addressed by the column counter
	// buf0 holds the previous row, buf1 the row before that
	logic [PIX_W-1:0] row_buf0 [ROW_DEPTH];
	logic [PIX_W-1:0] row_buf1 [ROW_DEPTH];

	// buffer read taps, same column one and two rows back
	logic [PIX_W-1:0] tap0;
	logic [PIX_W-1:0] tap1;

	// 3x3 window registers, [row][col], row 0 is the top row
	// col 2 holds the newest pixel of each row
	logic [PIX_W-1:0] win [3][3];

	// position of the incoming pixel in the padded frame
	logic [COL_W-1:0] col_cnt;
	logic [ROW_W-1:0] row_cnt;

	// window qualifiers for the incoming pixel
	logic rows_ready;
	logic col_ready;
	logic last_col;
	logic last_pixel;

	// read before write on the same address gives a full row of delay
	assign tap0 = row_buf0[col_cnt];
	assign tap1 = row_buf1[col_cnt];

	always_ff @(posedge clk) begin
		if (i_valid) begin
			// current pixel goes into buf0
			row_buf0[col_cnt] <= i_data;
			// pixel from one row back moves on to buf1
			row_buf1[col_cnt] <= tap0;
		end
	end

	// window shifts left by one column per accepted pixel
	always_ff @(posedge clk) begin
		if (i_valid) begin
			for (int r = 0; r < 3; r++) begin
				win[r][0] <= win[r][1];
				win[r][1] <= win[r][2];
			end
			// new right column, oldest row on top
			win[0][2] <= tap1;
			win[1][2] <= tap0;
			win[2][2] <= i_data;
		end
	end

	// three rows present once the bottom row of the window is padded row 2 or later
	assign rows_ready = (row_cnt >= ROW_W'(2));

	// first two pixels of a row only prime the window columns
	assign col_ready = (col_cnt >= COL_W'(2));

	assign last_col = (col_cnt == COL_W'(ROW_DEPTH - 1));

	// bottom-right padding pixel completes the window of the last interior pixel
	assign last_pixel = last_col && (row_cnt == ROW_W'(FRAME_ROWS - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt <= '0;
			row_cnt <= '0;
			o_win_valid <= 1'b0;
			o_win_done <= 1'b0;
		end
		else if (i_valid) begin
			// column counter wraps at the padded row length
			if (last_col) begin
				col_cnt <= '0;
				// row counter wraps once per padded frame
				if (row_cnt == ROW_W'(FRAME_ROWS - 1)) begin
					row_cnt <= '0;
				end
				else begin
					row_cnt <= row_cnt + 1'b1;
				end
			end
			else begin
				col_cnt <= col_cnt + 1'b1;
			end

			// window registers load on this beat, strobes line up with them
			o_win_valid <= rows_ready && col_ready;
			o_win_done <= last_pixel;
		end
	end

	// flatten row-major, top-left pixel in the highest slice
	for (genvar r = 0; r < 3; r++) begin : g_win_row
		for (genvar c = 0; c < 3; c++) begin : g_win_col
			assign o_win[(8 - (r * 3 + c)) * PIX_W +: PIX_W] = win[r][c];
		end
	end

endmodule

//--- hdl/sobel_conv.sv
module sobel_conv #(
	// 0 selects the horizontal kernel, 1 the vertical one
	parameter int DIR_Y = 0
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                i_valid,
	input  logic [9*edge_pkg::PIX_W-1:0]        i_win,
	input  logic                                i_win_valid,
	input  logic                                i_win_done,
	output logic signed [3*edge_pkg::GRAD_W-1:0] o_grad,
	output logic                                o_valid,
	output logic                                o_done
);
	import edge_pkg::*;

	// stage one, one partial sum per channel and kernel row
	// channel 0 is red
	logic signed [GRAD_W-1:0] row_part [3][3];

	// valid and done follow the two data stages
	logic [1:0] valid_sr;
	logic [1:0] done_sr;

	// kernel coefficient for this direction
	function automatic int coef(input int r, input int c);
		return (DIR_Y != 0) ? KERNEL_Y[r][c] : KERNEL_X[r][c];
	endfunction

	// weighted sum of one window row for one channel
	// pixels are unsigned, coefficients signed
	function automatic logic signed [GRAD_W-1:0] row_sum(
		input logic [9*PIX_W-1:0] win,
		input int r,
		input int ch
	);
		int acc;
		int base;
		acc = 0;
		for (int c = 0; c < 3; c++) begin
			// pixel (r, c) in the flat window, then the channel byte
			base = (8 - (r * 3 + c)) * PIX_W + (2 - ch) * CH_W;
			acc += coef(r, c) * int'(win[base +: CH_W]);
		end
		return GRAD_W'(acc);
	endfunction

	// stage one
	// row partial sums, at most +-510 for the centre row
	always_ff @(posedge clk) begin
		if (i_valid) begin
			for (int ch = 0; ch < 3; ch++) begin
				for (int r = 0; r < 3; r++) begin
					row_part[ch][r] <= row_sum(i_win, r, ch);
				end
			end
		end
	end

	// stage two
	// full channel gradient, red in the top slice
	always_ff @(posedge clk) begin
		if (i_valid) begin
			for (int ch = 0; ch < 3; ch++) begin
				o_grad[(2 - ch) * GRAD_W +: GRAD_W] <=
					row_part[ch][0] + row_part[ch][1] + row_part[ch][2];
			end
		end
	end

	// strobes stall with the data
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_sr <= '0;
			done_sr <= '0;
		end
		else if (i_valid) begin
			valid_sr <= {valid_sr[0], i_win_valid};
			done_sr <= {done_sr[0], i_win_done};
		end
	end

	assign o_valid = valid_sr[1];
	assign o_done = done_sr[1];

endmodule

//--- hdl/edge_combine.sv
module edge_combine (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           i_valid,
	input  logic [3*edge_pkg::GRAD_W-1:0]  i_grad_x,
	input  logic [3*edge_pkg::GRAD_W-1:0]  i_grad_y,
	input  logic                           i_grad_valid,
	input  logic                           i_grad_done,
	output logic                           o_valid,
	output logic                           o_done,
	output logic [edge_pkg::PIX_W-1:0]     o_data
);
	import edge_pkg::*;

	// registered strobes, one beat behind the gradients
	logic valid_q;
	logic done_q;

	for (genvar ch = 0; ch < 3; ch++) begin : g_ch
		// channel gradients, red is ch 0 in the top slice
		logic signed [GRAD_W-1:0] gx;
		logic signed [GRAD_W-1:0] gy;

		// magnitudes, at most 1020 each
		logic [GRAD_W-1:0] abs_x;
		logic [GRAD_W-1:0] abs_y;

		// sum of magnitudes fits in 11 bits
		logic [GRAD_W-1:0] mag;

		// clamped channel result
		logic [CH_W-1:0] res;

		assign gx = i_grad_x[(2 - ch) * GRAD_W +: GRAD_W];
		assign gy = i_grad_y[(2 - ch) * GRAD_W +: GRAD_W];

		// -2048 never occurs, so the negation cannot overflow
		assign abs_x = gx[GRAD_W-1] ? -gx : gx;
		assign abs_y = gy[GRAD_W-1] ? -gy : gy;

		assign mag = abs_x + abs_y;

		always_ff @(posedge clk) begin
			if (i_valid) begin
				// any bit above the channel width means saturate at 255
				if (mag[GRAD_W-1:CH_W] != '0) begin
					res <= {CH_W{1'b1}};
				end
				else begin
					res <= mag[CH_W-1:0];
				end
			end
		end

		assign o_data[(2 - ch) * CH_W +: CH_W] = res;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
			done_q <= 1'b0;
		end
		else if (i_valid) begin
			valid_q <= i_grad_valid;
			done_q <= i_grad_done;
		end
	end

	// results only leave on accepted beats
	assign o_valid = i_valid & valid_q;
	assign o_done = i_valid & done_q;

endmodule

//--- hdl/edge_filter_top.sv
module edge_filter_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        i_valid,
	input  logic [edge_pkg::PIX_W-1:0]  i_data,
	output logic                        o_valid,
	output logic                        o_done,
	output logic [edge_pkg::PIX_W-1:0]  o_data
);
	import edge_pkg::*;

	// 3x3 window and its strobes, shared by both convolvers
	logic [9*PIX_W-1:0] win;
	logic               win_valid;
	logic               win_done;

	// per-channel gradients, red in the top slice
	logic signed [3*GRAD_W-1:0] grad_x;
	logic signed [3*GRAD_W-1:0] grad_y;

	// strobes from the horizontal convolver
	// the vertical one has identical timing
	logic grad_valid;
	logic grad_done;

	line_window line_window_inst (
		.clk         (clk),
		.reset       (reset),
		.i_valid     (i_valid),
		.i_data      (i_data),
		.o_win       (win),
		.o_win_valid (win_valid),
		.o_win_done  (win_done)
	);

	// horizontal gradient
	sobel_conv #(
		.DIR_Y (0)
	) grad_x_conv (
		.clk         (clk),
		.reset       (reset),
		.i_valid     (i_valid),
		.i_win       (win),
		.i_win_valid (win_valid),
		.i_win_done  (win_done),
		.o_grad      (grad_x),
		.o_valid     (grad_valid),
		.o_done      (grad_done)
	);

	// vertical gradient, strobes come from the x instance
	sobel_conv #(
		.DIR_Y (1)
	) grad_y_conv (
		.clk         (clk),
		.reset       (reset),
		.i_valid     (i_valid),
		.i_win       (win),
		.i_win_valid (win_valid),
		.i_win_done  (win_done),
		.o_grad      (grad_y),
		.o_valid     (),
		.o_done      ()
	);

	edge_combine edge_combine_inst (
		.clk          (clk),
		.reset        (reset),
		.i_valid      (i_valid),
		.i_grad_x     (grad_x),
		.i_grad_y     (grad_y),
		.i_grad_valid (grad_valid),
		.i_grad_done  (grad_done),
		.o_valid      (o_valid),
		.o_done       (o_done),
		.o_data       (o_data)
	);

endmodule

//--- testbench/tb_edge_filter.sv
module tb_edge_filter;
	timeunit 1ns;
	timeprecision 100ps;
	import edge_pkg::*;

	typedef enum int {
		PAT_ZERO,
		PAT_CONST,
		PAT_HRAMP,
		PAT_VRAMP,
		PAT_CHECK,
		PAT_RANDOM
	} pattern_t;

	// table row with pattern, stall percentage and frames streamed back to back
	typedef struct packed {
		pattern_t pattern;
		int       stall_pct;
		int       frames;
	} test_row_t;

	localparam int NUM_TESTS = 9;
	localparam int MAX_GAP = 8;
	localparam int RESULT_TIMEOUT = 200;
	// accepted beat on which the first result of a frame must show
	localparam int FIRST_RESULT_BEAT = 2 * ROW_DEPTH + 2 + PIPE_BEATS;
	localparam logic [31:0] SEED = 32'd68526;

	// random rows share one pixel seed and must give matching results
	localparam test_row_t TEST_TABLE [NUM_TESTS] = '{
		'{PAT_ZERO,   0,  2},
		'{PAT_CONST,  20, 2},
		'{PAT_HRAMP,  0,  1},
		'{PAT_VRAMP,  10, 1},
		'{PAT_CHECK,  0,  2},
		'{PAT_RANDOM, 0,  3},
		'{PAT_RANDOM, 30, 3},
		'{PAT_RANDOM, 70, 3},
		'{PAT_HRAMP,  50, 3}
	};

	logic             clk;
	logic             reset;
	logic             i_valid;
	logic [PIX_W-1:0] i_data;
	logic             o_valid;
	logic             o_done;
	logic [PIX_W-1:0] o_data;

	// padded frame being streamed
	logic [PIX_W-1:0] frame_pix [FRAME_ROWS][ROW_DEPTH];

	// expected and collected results of the current table row
	logic [PIX_W-1:0] exp_pix [$];
	logic             exp_done [$];
	logic [PIX_W-1:0] got_pix [$];
	logic             got_done [$];
	// results of the first random row
	logic [PIX_W-1:0] ref_pix [$];
	bit               have_ref;

	logic [31:0] stall_state;
	logic [31:0] pix_state;
	int          beat_cnt;
	bit          failed;

	edge_filter_top edge_filter_top_inst (
		.clk     (clk),
		.reset   (reset),
		.i_valid (i_valid),
		.i_data  (i_data),
		.o_valid (o_valid),
		.o_done  (o_done),
		.o_data  (o_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [PIX_W-1:0] rgb(input int r, input int g, input int b);
		return {8'(r), 8'(g), 8'(b)};
	endfunction

	task automatic stop_with_failure();
		failed = 1'b1;
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		stop_with_failure();
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		stop_with_failure();
	endtask

	task automatic check_pixel(input logic [PIX_W-1:0] got, input logic [PIX_W-1:0] exp,
		input int idx);
		if (got !== exp) begin
			report_mismatch($sformatf("pixel %0d: got %06h, expected %06h", idx, got, exp));
		end
	endtask

	task automatic check_done(input logic got, input logic exp, input int idx);
		if (got !== exp) begin
			report_mismatch($sformatf("done at pixel %0d: got %0b, expected %0b", idx, got, exp));
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic drive_beat(input logic valid, input logic [PIX_W-1:0] data);
		@(posedge clk);
		#1;
		i_valid = valid;
		i_data = data;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		reset = 1'b1;
		i_valid = 1'b0;
		i_data = '0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	// idle beats with junk data and a count drawn from the stall percentage
	task automatic insert_gaps(input int pct);
		for (int g = 0; g < MAX_GAP; g++) begin
			stall_state = lcg_step(stall_state);
			if (int'(stall_state[30:16]) % 100 >= pct) break;
			drive_beat(1'b0, stall_state[31:8]);
		end
	endtask

	task automatic build_frame(input pattern_t pat, input int f);
		for (int y = 0; y < FRAME_ROWS; y++) begin
			for (int x = 0; x < ROW_DEPTH; x++) begin
				if (y == 0 || y == FRAME_ROWS - 1 || x == 0 || x == ROW_DEPTH - 1) begin
					// zero padding ring
					frame_pix[y][x] = '0;
				end
				else begin
					case (pat)
						PAT_ZERO:  frame_pix[y][x] = '0;
						PAT_CONST: frame_pix[y][x] = rgb(16 + f * 40, 100, 200);
						PAT_HRAMP: frame_pix[y][x] = rgb(x * 30, x * 12, 255 - x * 20);
						PAT_VRAMP: frame_pix[y][x] = rgb(y * 40, 255 - y * 35, y * 10);
						// 2x2 blocks bright enough to saturate
						PAT_CHECK: frame_pix[y][x] = (((x / 2) + (y / 2)) % 2 != 0) ?
							24'hffe0ff : 24'h000000;
						default: begin
							pix_state = lcg_step(pix_state);
							frame_pix[y][x] = pix_state[31:8];
						end
					endcase
				end
			end
		end
	endtask

	// |gx| + |gy| per channel clamped to 255
	function automatic logic [PIX_W-1:0] sobel_model(input int y, input int x);
		logic [PIX_W-1:0] res;
		int gx;
		int gy;
		int p;
		int mag;
		res = '0;
		for (int ch = 0; ch < 3; ch++) begin
			gx = 0;
			gy = 0;
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					p = int'(frame_pix[y - 1 + r][x - 1 + c][(2 - ch) * CH_W +: CH_W]);
					gx += KERNEL_X[r][c] * p;
					gy += KERNEL_Y[r][c] * p;
				end
			end
			if (gx < 0) gx = -gx;
			if (gy < 0) gy = -gy;
			mag = (gx + gy > 255) ? 255 : gx + gy;
			res[(2 - ch) * CH_W +: CH_W] = CH_W'(mag);
		end
		return res;
	endfunction

	// interior positions in raster order with done on the last one
	task automatic predict_frame();
		for (int y = 1; y <= IMG_HEIGHT; y++) begin
			for (int x = 1; x <= IMG_WIDTH; x++) begin
				exp_pix.push_back(sobel_model(y, x));
				exp_done.push_back(y == IMG_HEIGHT && x == IMG_WIDTH);
			end
		end
	endtask

	task automatic stream_frame(input int pct);
		for (int y = 0; y < FRAME_ROWS; y++) begin
			for (int x = 0; x < ROW_DEPTH; x++) begin
				insert_gaps(pct);
				drive_beat(1'b1, frame_pix[y][x]);
			end
		end
	endtask

	task automatic wait_results(input int count);
		int waited;
		waited = 0;
		while (got_pix.size() < count) begin
			if (waited >= RESULT_TIMEOUT) begin
				abort_run($sformatf("timed out waiting for %0d results, only %0d arrived",
					count, got_pix.size()));
			end
			else begin
				@(posedge clk);
				waited++;
			end
		end
	endtask

	task automatic compare_results();
		if (got_pix.size() != exp_pix.size()) begin
			report_mismatch($sformatf("got %0d results, expected %0d",
				got_pix.size(), exp_pix.size()));
		end
		else begin
			for (int i = 0; i < exp_pix.size(); i++) begin
				check_pixel(got_pix[i], exp_pix[i], i);
				check_done(got_done[i], exp_done[i], i);
			end
		end
	endtask

	// same frames under any stall rate give the same sequence
	task automatic compare_with_reference();
		if (!have_ref) begin
			ref_pix = got_pix;
			have_ref = 1'b1;
		end
		else if (ref_pix.size() != got_pix.size()) begin
			report_mismatch($sformatf("stalled run gave %0d results, reference %0d",
				got_pix.size(), ref_pix.size()));
		end
		else begin
			for (int i = 0; i < ref_pix.size(); i++) begin
				check_pixel(got_pix[i], ref_pix[i], i);
			end
		end
	endtask

	task automatic run_test(input test_row_t row);
		exp_pix.delete();
		exp_done.delete();
		got_pix.delete();
		got_done.delete();
		pix_state = SEED;
		$display("pattern %s, %0d%% stalls, %0d frames", row.pattern.name(),
			row.stall_pct, row.frames);
		for (int f = 0; f < row.frames; f++) begin
			build_frame(row.pattern, f);
			predict_frame();
			stream_frame(row.stall_pct);
		end
		// trailing zero beats push the last results out
		repeat (PIPE_BEATS) begin
			insert_gaps(row.stall_pct);
			drive_beat(1'b1, '0);
		end
		drive_beat(1'b0, '0);
		wait_results(exp_pix.size());
		compare_results();
		if (row.pattern == PAT_RANDOM) compare_with_reference();
		// realign the line window counters for the next row
		apply_reset();
	endtask

	// outputs sampled mid-cycle well after the input change
	always @(negedge clk) begin
		if (reset) begin
			beat_cnt = 0;
			if (o_valid || o_done) abort_run("o_valid or o_done high during reset");
		end
		else if (o_valid && !i_valid) begin
			abort_run("o_valid high on a beat without i_valid");
		end
		else if (o_done && !o_valid) begin
			abort_run("o_done high without o_valid");
		end
		else if (i_valid) begin
			if (o_valid && beat_cnt < FIRST_RESULT_BEAT) begin
				abort_run("o_valid rose before the first window was complete");
			end
			else if (!o_valid && beat_cnt == FIRST_RESULT_BEAT) begin
				abort_run("first result of the frame did not show on time");
			end
			else begin
				if (o_valid) begin
					got_pix.push_back(o_data);
					got_done.push_back(o_done);
				end
				beat_cnt++;
			end
		end
	end

	initial begin
		reset = 1'b1;
		i_valid = 1'b0;
		i_data = '0;
		stall_state = SEED;
		pix_state = SEED;
		have_ref = 1'b0;
		failed = 1'b0;
		beat_cnt = 0;
		// reset is already high, release it after two rising edges
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			run_test(TEST_TABLE[t]);
		end
		drive_beat(1'b0, '0);
		if (!failed) begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else begin
			stop_with_failure();
		end
	end

endmodule

//--- build.f
hdl/edge_pkg.sv
hdl/line_window.sv
hdl/sobel_conv.sv
hdl/edge_combine.sv
hdl/edge_filter_top.sv
testbench/tb_edge_filter.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the edge filter testbench with Verilator.
# Exits non-zero unless the log holds the pass message.

cd "$(dirname "$0")" || exit 1

TOP=tb_edge_filter
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing \
	-f build.f \
	--top-module "$TOP" \
	-Mdir "$BUILD_DIR" \
	-o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -F -q "*** TEST PASSED ***" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi
